/* hw/bp_pkg.sv */
// Constants shared by the BTB RTL and its testbench
// PCs are word aligned, so the low PC_ALIGN_BITS never reach the table
// Counters are two-bit saturating, MSB set means predict taken
`default_nettype none

package bp_pkg;

    // Program counter and branch target width
    localparam int XLEN = 32;

    // Low PC bits dropped before indexing (4-byte instructions)
    localparam int PC_ALIGN_BITS = 2;

    // Direction counter
    localparam int CTR_WIDTH = 2;
    localparam logic [CTR_WIDTH-1:0] CTR_MAX        = 2'd3; // Strongly taken
    localparam logic [CTR_WIDTH-1:0] CTR_WEAK_TAKEN = 2'd2; // Value on allocation

    // Width of one tag-RAM entry, laid out as {valid, tag, counter}
    function automatic int entry_width(input int tag_width);
        return 1 + tag_width + CTR_WIDTH;
    endfunction

endpackage

`default_nettype wire

/* hw/branch_predictor_ram.sv */
// Simple dual-port RAM, one write port and one registered read port
// Contents start at zero via an initial block (simulation and FPGA only)
// Read of the address being written in the same cycle returns unspecified data
`timescale 1ns/1ps
`default_nettype none

module branch_predictor_ram #(
    parameter int DATA_WIDTH = 20,
    parameter int DEPTH      = 512
) (
    input  logic                     clk,
    input  logic [$clog2(DEPTH)-1:0] write_addr,
    input  logic                     write_en,
    input  logic [$clog2(DEPTH)-1:0] read_addr,
    input  logic                     read_en,
    input  logic [DATA_WIDTH-1:0]    write_data,
    output logic [DATA_WIDTH-1:0]    read_data
);

    logic [DATA_WIDTH-1:0] mem [DEPTH];

    // All-zero start clears every valid bit in the tag RAM
    initial begin
        foreach (mem[i]) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (write_en) begin
            mem[write_addr] <= write_data;
        end
    end

    // Output register holds its value while read_en is low
    always_ff @(posedge clk) begin
        if (read_en) begin
            read_data <= mem[read_addr];
        end
    end

endmodule

`default_nettype wire

/* hw/bp_lookup.sv */
// Lookup half of the BTB, answers a fetch PC exactly one cycle later
// Prediction outputs are only meaningful while predict_valid is high
// A lookup racing a table write to the same index may see stale data
`timescale 1ns/1ps
`default_nettype none

module bp_lookup #(
    parameter int TABLE_DEPTH = 512,
    parameter int TAG_WIDTH   = 10
) (
    input  logic                                      clk,
    input  logic                                      arst_n,
    // Fetch stage request
    input  logic                                      fetch_valid,
    input  logic [bp_pkg::XLEN-1:0]                   fetch_pc,
    // Tag RAM read port
    output logic [$clog2(TABLE_DEPTH)-1:0]            tag_read_addr,
    output logic                                      tag_read_en,
    input  logic [bp_pkg::entry_width(TAG_WIDTH)-1:0] tag_read_data,
    // Target RAM read port
    output logic [$clog2(TABLE_DEPTH)-1:0]            target_read_addr,
    output logic                                      target_read_en,
    input  logic [bp_pkg::XLEN-1:0]                   target_read_data,
    // Prediction, one cycle after the request
    output logic                                      predict_valid,
    output logic                                      predict_hit,
    output logic                                      predict_taken,
    output logic [bp_pkg::XLEN-1:0]                   predict_target,
    output logic [bp_pkg::CTR_WIDTH-1:0]              predict_counter
);

    import bp_pkg::*;

    localparam int IDX_W   = $clog2(TABLE_DEPTH);
    localparam int TAG_LSB = PC_ALIGN_BITS + IDX_W; // First tag bit of the PC

    logic [TAG_WIDTH-1:0] fetch_tag;  // Tag of the PC being looked up now
    logic [TAG_WIDTH-1:0] lookup_tag; // Same tag, aligned with the RAM output
    logic                 entry_valid;
    logic [TAG_WIDTH-1:0] entry_tag;
    logic [CTR_WIDTH-1:0] entry_ctr;
    logic                 tag_match;

    // Both RAMs share the index, reads only on a real fetch
    assign tag_read_addr    = fetch_pc[PC_ALIGN_BITS +: IDX_W];
    assign target_read_addr = fetch_pc[PC_ALIGN_BITS +: IDX_W];
    assign tag_read_en      = fetch_valid;
    assign target_read_en   = fetch_valid;

    assign fetch_tag = fetch_pc[TAG_LSB +: TAG_WIDTH];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            predict_valid <= 1'b0;
        end else begin
            predict_valid <= fetch_valid; // Fixed one-cycle latency
        end
    end

    // Tag follows the RAM read enable so both stay paired
    always_ff @(posedge clk) begin
        if (fetch_valid) begin
            lookup_tag <= fetch_tag;
        end
    end

    assign {entry_valid, entry_tag, entry_ctr} = tag_read_data;

    assign tag_match = entry_valid && (entry_tag == lookup_tag);

    // Gated by predict_valid so an idle read register never shows a hit
    assign predict_hit     = predict_valid && tag_match;
    assign predict_taken   = predict_hit && entry_ctr[CTR_WIDTH-1]; // Counter MSB
    assign predict_target  = predict_hit ? target_read_data : '0;
    assign predict_counter = predict_hit ? entry_ctr : '0;

endmodule

`default_nettype wire

/* hw/bp_update.sv */
// Training half of the BTB, takes resolved branches from execute
// update_hit and update_counter must be the metadata given at prediction time
// Writes land one edge after the update is registered, no back-pressure
`timescale 1ns/1ps
`default_nettype none

module bp_update #(
    parameter int TABLE_DEPTH = 512,
    parameter int TAG_WIDTH   = 10
) (
    input  logic                                      clk,
    input  logic                                      arst_n,
    // Resolved branch from execute
    input  logic                                      update_valid,
    input  logic [bp_pkg::XLEN-1:0]                   update_pc,
    input  logic                                      update_taken,
    input  logic [bp_pkg::XLEN-1:0]                   update_target,
    input  logic                                      update_hit,
    input  logic [bp_pkg::CTR_WIDTH-1:0]              update_counter,
    // Tag RAM write port
    output logic [$clog2(TABLE_DEPTH)-1:0]            tag_write_addr,
    output logic                                      tag_write_en,
    output logic [bp_pkg::entry_width(TAG_WIDTH)-1:0] tag_write_data,
    // Target RAM write port
    output logic [$clog2(TABLE_DEPTH)-1:0]            target_write_addr,
    output logic                                      target_write_en,
    output logic [bp_pkg::XLEN-1:0]                   target_write_data
);

    import bp_pkg::*;

    localparam int IDX_W   = $clog2(TABLE_DEPTH);
    localparam int TAG_LSB = PC_ALIGN_BITS + IDX_W;
    localparam logic [CTR_WIDTH-1:0] CTR_ONE = 1;

    logic [IDX_W-1:0]     upd_idx;
    logic [TAG_WIDTH-1:0] upd_tag;
    logic [CTR_WIDTH-1:0] next_ctr;       // Trained counter value
    logic                 tag_we_next;
    logic                 target_we_next;

    assign upd_idx = update_pc[PC_ALIGN_BITS +: IDX_W];
    assign upd_tag = update_pc[TAG_LSB +: TAG_WIDTH];

    always_comb begin
        next_ctr       = CTR_WEAK_TAKEN; // Allocation value on a taken miss
        tag_we_next    = 1'b0;
        target_we_next = 1'b0;
        if (update_valid) begin
            if (update_hit) begin
                // Saturating move toward the outcome
                if (update_taken) begin
                    next_ctr = (update_counter == CTR_MAX) ? CTR_MAX : update_counter + CTR_ONE;
                end else begin
                    next_ctr = (update_counter == '0) ? '0 : update_counter - CTR_ONE;
                end
                tag_we_next    = 1'b1;
                target_we_next = update_taken; // Keep old target when not taken
            end else if (update_taken) begin
                tag_we_next    = 1'b1;
                target_we_next = 1'b1;
            end
            // Not-taken miss writes nothing
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tag_write_en    <= 1'b0;
            target_write_en <= 1'b0;
        end else begin
            tag_write_en    <= tag_we_next;
            target_write_en <= target_we_next;
        end
    end

    // Payload only loads on a real update
    always_ff @(posedge clk) begin
        if (update_valid) begin
            tag_write_addr    <= upd_idx;
            target_write_addr <= upd_idx;
            tag_write_data    <= {1'b1, upd_tag, next_ctr}; // Valid, tag, counter
            target_write_data <= update_target;
        end
    end

endmodule

`default_nettype wire

/* hw/branch_predictor.sv */
// Branch target buffer with two-bit direction counters
// TABLE_DEPTH must be a power of two; log2(depth) + TAG_WIDTH + 2 <= 32
// Table starts empty only through the RAMs' zero init, there is no flush
// Lookup latency is one cycle, an update is visible two cycles later
`timescale 1ns/1ps
`default_nettype none

module branch_predictor #(
    parameter int TABLE_DEPTH = 512,
    parameter int TAG_WIDTH   = 10
) (
    input  logic                         clk,
    input  logic                         arst_n,
    // Lookup port
    input  logic                         fetch_valid,
    input  logic [bp_pkg::XLEN-1:0]      fetch_pc,
    output logic                         predict_valid,
    output logic                         predict_hit,
    output logic                         predict_taken,
    output logic [bp_pkg::XLEN-1:0]      predict_target,
    output logic [bp_pkg::CTR_WIDTH-1:0] predict_counter,
    // Update port
    input  logic                         update_valid,
    input  logic [bp_pkg::XLEN-1:0]      update_pc,
    input  logic                         update_taken,
    input  logic [bp_pkg::XLEN-1:0]      update_target,
    input  logic                         update_hit,
    input  logic [bp_pkg::CTR_WIDTH-1:0] update_counter
);

    import bp_pkg::*;

    localparam int IDX_W   = $clog2(TABLE_DEPTH);
    localparam int ENTRY_W = entry_width(TAG_WIDTH); // {valid, tag, counter}

    // Tag RAM
    logic [IDX_W-1:0]   tag_read_addr;
    logic               tag_read_en;
    logic [ENTRY_W-1:0] tag_read_data;
    logic [IDX_W-1:0]   tag_write_addr;
    logic               tag_write_en;
    logic [ENTRY_W-1:0] tag_write_data;

    // Target RAM
    logic [IDX_W-1:0]   target_read_addr;
    logic               target_read_en;
    logic [XLEN-1:0]    target_read_data;
    logic [IDX_W-1:0]   target_write_addr;
    logic               target_write_en;
    logic [XLEN-1:0]    target_write_data;

    bp_lookup #(
        .TABLE_DEPTH(TABLE_DEPTH),
        .TAG_WIDTH  (TAG_WIDTH)
    ) lookup_unit (
        .clk             (clk),
        .arst_n          (arst_n),
        .fetch_valid     (fetch_valid),
        .fetch_pc        (fetch_pc),
        .tag_read_addr   (tag_read_addr),
        .tag_read_en     (tag_read_en),
        .tag_read_data   (tag_read_data),
        .target_read_addr(target_read_addr),
        .target_read_en  (target_read_en),
        .target_read_data(target_read_data),
        .predict_valid   (predict_valid),
        .predict_hit     (predict_hit),
        .predict_taken   (predict_taken),
        .predict_target  (predict_target),
        .predict_counter (predict_counter)
    );

    bp_update #(
        .TABLE_DEPTH(TABLE_DEPTH),
        .TAG_WIDTH  (TAG_WIDTH)
    ) update_unit (
        .clk              (clk),
        .arst_n           (arst_n),
        .update_valid     (update_valid),
        .update_pc        (update_pc),
        .update_taken     (update_taken),
        .update_target    (update_target),
        .update_hit       (update_hit),
        .update_counter   (update_counter),
        .tag_write_addr   (tag_write_addr),
        .tag_write_en     (tag_write_en),
        .tag_write_data   (tag_write_data),
        .target_write_addr(target_write_addr),
        .target_write_en  (target_write_en),
        .target_write_data(target_write_data)
    );

    branch_predictor_ram #(
        .DATA_WIDTH(ENTRY_W),
        .DEPTH     (TABLE_DEPTH)
    ) tag_ram (
        .clk       (clk),
        .write_addr(tag_write_addr),
        .write_en  (tag_write_en),
        .read_addr (tag_read_addr),
        .read_en   (tag_read_en),
        .write_data(tag_write_data),
        .read_data (tag_read_data)
    );

    branch_predictor_ram #(
        .DATA_WIDTH(XLEN),
        .DEPTH     (TABLE_DEPTH)
    ) target_ram (
        .clk       (clk),
        .write_addr(target_write_addr),
        .write_en  (target_write_en),
        .read_addr (target_read_addr),
        .read_en   (target_read_en),
        .write_data(target_write_data),
        .read_data (target_read_data)
    );

endmodule

`default_nettype wire

/* sim/tb_branch_predictor.sv */
// Self-checking testbench for the BTB with 16 entries and 4 tag bits so aliasing is common
// Expected predictions come from a table model trained by the same resolved branches
// Every update is followed by an idle cycle so its RAM write lands before the next lookup
`timescale 1ns/1ps
`default_nettype none

module tb_branch_predictor;

    import bp_pkg::*;

    localparam int TABLE_DEPTH = 16;
    localparam int TAG_WIDTH   = 4;
    localparam int IDX_W       = $clog2(TABLE_DEPTH);
    localparam int TAG_LSB     = PC_ALIGN_BITS + IDX_W;
    localparam int REF_W       = 2 + XLEN + CTR_WIDTH;  // {hit, taken, target, counter}
    localparam int CLK_PERIOD  = 8;
    localparam int NUM_RANDOM  = 400;
    localparam int NUM_OPS     = NUM_RANDOM + 50;      // Random plus directed operations
    localparam int TIMEOUT_NS  = NUM_OPS * 4 * CLK_PERIOD + 1000;

    // Directed PCs where A and C share index 2 with tags 1 and 2
    localparam logic [XLEN-1:0] PC_A  = 32'h0000_2048;
    localparam logic [XLEN-1:0] PC_B  = 32'h0000_2010;
    localparam logic [XLEN-1:0] PC_C  = 32'h0000_2088;
    localparam logic [XLEN-1:0] TGT_A = 32'h0000_4000;
    localparam logic [XLEN-1:0] TGT_B = 32'h0000_5000;
    localparam logic [XLEN-1:0] TGT_C = 32'h0000_6000;

    logic                 clk;
    logic                 arst_n;
    logic                 fetch_valid;
    logic [XLEN-1:0]      fetch_pc;
    logic                 predict_valid;
    logic                 predict_hit;
    logic                 predict_taken;
    logic [XLEN-1:0]      predict_target;
    logic [CTR_WIDTH-1:0] predict_counter;
    logic                 update_valid;
    logic [XLEN-1:0]      update_pc;
    logic                 update_taken;
    logic [XLEN-1:0]      update_target;
    logic                 update_hit;
    logic [CTR_WIDTH-1:0] update_counter;

    // Table model indexed like the DUT
    logic                 m_valid  [TABLE_DEPTH];
    logic [TAG_WIDTH-1:0] m_tag    [TABLE_DEPTH];
    logic [CTR_WIDTH-1:0] m_ctr    [TABLE_DEPTH];
    logic [XLEN-1:0]      m_target [TABLE_DEPTH];

    logic [REF_W-1:0] exp_ref = '0;       // Expected answer for the lookup driven now
    logic [REF_W-1:0] chk_ref = '0;       // Held for the cycle the DUT answers
    logic [XLEN-1:0]  chk_pc  = '0;
    logic             chk_pending = 1'b0; // A lookup was taken at the last edge
    logic [31:0]      rng;

    branch_predictor #(
        .TABLE_DEPTH(TABLE_DEPTH),
        .TAG_WIDTH  (TAG_WIDTH)
    ) uut (
        .clk            (clk),
        .arst_n         (arst_n),
        .fetch_valid    (fetch_valid),
        .fetch_pc       (fetch_pc),
        .predict_valid  (predict_valid),
        .predict_hit    (predict_hit),
        .predict_taken  (predict_taken),
        .predict_target (predict_target),
        .predict_counter(predict_counter),
        .update_valid   (update_valid),
        .update_pc      (update_pc),
        .update_taken   (update_taken),
        .update_target  (update_target),
        .update_hit     (update_hit),
        .update_counter (update_counter)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Hit needs a valid entry with the PC's tag and taken is the counter MSB
    function automatic logic [REF_W-1:0] predict_ref(input logic [XLEN-1:0] pc);
        logic [IDX_W-1:0] idx;
        idx = pc[PC_ALIGN_BITS +: IDX_W];
        if (m_valid[idx] && (m_tag[idx] == pc[TAG_LSB +: TAG_WIDTH])) begin
            return {1'b1, m_ctr[idx][CTR_WIDTH-1], m_target[idx], m_ctr[idx]};
        end
        return '0; // Miss shows zero target and counter
    endfunction

    // Pool of 16 PCs on 4 indexes with 4 tags each
    function automatic logic [XLEN-1:0] pool_pc(input logic [31:0] r);
        logic [XLEN-1:0] pc;
        pc = 32'h0001_0000;
        pc[PC_ALIGN_BITS +: 2] = r[21:20];
        pc[TAG_LSB +: 2]       = r[25:24];
        return pc;
    endfunction

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("Test FAILED");
        $fatal(1);
    endtask

    // One lookup cycle started right after a falling edge
    task automatic lookup(input logic [XLEN-1:0] pc);
        fetch_valid  = 1'b1;
        fetch_pc     = pc;
        update_valid = 1'b0;
        exp_ref      = predict_ref(pc);
        @(negedge clk);
    endtask

    // Drives one resolved branch and trains the model the same way
    task automatic train(input logic [XLEN-1:0] pc, input logic taken,
                         input logic [XLEN-1:0] target);
        logic [REF_W-1:0]     pred;
        logic [IDX_W-1:0]     idx;
        logic [CTR_WIDTH-1:0] ctr;
        pred           = predict_ref(pc);   // Metadata as seen at prediction time
        idx            = pc[PC_ALIGN_BITS +: IDX_W];
        ctr            = pred[CTR_WIDTH-1:0];
        fetch_valid    = 1'b0;
        update_valid   = 1'b1;
        update_pc      = pc;
        update_taken   = taken;
        update_target  = target;
        update_hit     = pred[REF_W-1];
        update_counter = ctr;
        if (pred[REF_W-1]) begin
            if (taken) begin
                m_ctr[idx]    = (ctr == CTR_MAX) ? CTR_MAX : ctr + 2'd1;
                m_target[idx] = target;
            end else begin
                m_ctr[idx] = (ctr == 2'd0) ? 2'd0 : ctr - 2'd1;
            end
        end else if (taken) begin
            m_valid[idx]  = 1'b1;             // Allocate weakly taken
            m_tag[idx]    = pc[TAG_LSB +: TAG_WIDTH];
            m_ctr[idx]    = CTR_WEAK_TAKEN;
            m_target[idx] = target;
        end
        @(negedge clk);
        update_valid = 1'b0;
        @(negedge clk);                     // Write lands at the end of this cycle
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Latch what was asked at the rising edge and compare half a cycle later
    always @(posedge clk) begin
        chk_pending = arst_n && fetch_valid;
        chk_ref     = exp_ref;
        chk_pc      = fetch_pc;
    end

    always @(negedge clk) begin
        if (arst_n) begin
            assert (predict_valid == chk_pending)
            else stop_on_error($sformatf("ERROR predict_valid got %h expected %h",
                                         predict_valid, chk_pending));
            if (chk_pending) begin
                assert (predict_hit == chk_ref[REF_W-1])
                else stop_on_error($sformatf("ERROR predict_hit got %h expected %h pc %h",
                                             predict_hit, chk_ref[REF_W-1], chk_pc));
                assert (predict_taken == chk_ref[REF_W-2])
                else stop_on_error($sformatf("ERROR predict_taken got %h expected %h pc %h",
                                             predict_taken, chk_ref[REF_W-2], chk_pc));
                assert (predict_target == chk_ref[CTR_WIDTH +: XLEN])
                else stop_on_error($sformatf("ERROR predict_target got %h expected %h pc %h",
                                             predict_target, chk_ref[CTR_WIDTH +: XLEN],
                                             chk_pc));
                assert (predict_counter == chk_ref[CTR_WIDTH-1:0])
                else stop_on_error($sformatf("ERROR predict_counter got %h expected %h pc %h",
                                             predict_counter, chk_ref[CTR_WIDTH-1:0], chk_pc));
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        stop_on_error("Run timed out before all operations completed");
    end

    initial begin
        logic [XLEN-1:0] pc;
        logic            taken;
        logic [XLEN-1:0] tgt;
        logic [8:0]      outcomes;
        arst_n         = 1'b0;
        fetch_valid    = 1'b0;
        fetch_pc       = '0;
        update_valid   = 1'b0;
        update_pc      = '0;
        update_taken   = 1'b0;
        update_target  = '0;
        update_hit     = 1'b0;
        update_counter = '0;
        rng            = 32'd92;
        outcomes       = 9'b1_0000_0111; // Up to saturation, down past zero, one step up
        foreach (m_valid[i]) begin
            m_valid[i]  = 1'b0;          // RAMs start all zero
            m_tag[i]    = '0;
            m_ctr[i]    = '0;
            m_target[i] = '0;
        end
        repeat (2) @(negedge clk);
        arst_n = 1'b1;
        repeat (3) @(negedge clk);       // predict_valid must stay low here
        lookup(PC_A);                    // Cold table misses
        lookup(PC_B);
        lookup(PC_C);
        train(PC_A, 1'b1, TGT_A);        // Allocation on a taken miss
        lookup(PC_A);
        for (int i = 0; i < 9; i++) begin
            tgt = outcomes[i] ? TGT_A + 32'(16 * i) : 32'hdead_bee0; // Junk when not taken
            train(PC_A, outcomes[i], tgt);
            lookup(PC_A);
        end
        train(PC_B, 1'b0, TGT_B);        // Not-taken miss writes nothing
        lookup(PC_B);
        lookup(PC_C);                    // Same index with another tag
        train(PC_C, 1'b1, TGT_C);
        lookup(PC_C);
        lookup(PC_A);                    // Evicted by PC_C
        for (int n = 0; n < NUM_RANDOM; n++) begin
            rng = lcg_next(rng);
            pc  = pool_pc(rng);
            if (rng[31:30] == 2'b00) begin
                taken = rng[27] | rng[26]; // Mostly taken so entries get allocated
                rng   = lcg_next(rng);
                train(pc, taken, {rng[31:2], 2'b00});
            end else begin
                lookup(pc);                // Runs of these go back to back
            end
        end
        fetch_valid  = 1'b0;
        update_valid = 1'b0;
        repeat (2) @(negedge clk);       // Let the last answer be checked
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
hw/bp_pkg.sv
hw/branch_predictor_ram.sv
hw/bp_lookup.sv
hw/bp_update.sv
hw/branch_predictor.sv
sim/tb_branch_predictor.sv
